// ==== rtl/execute_pkg.sv ====
// ######################################
// Shared types for the execute stage
// Words, register numbers, op encodings
// ######################################

package execute_pkg;

  // Data word or address
  typedef logic [31:0] word_t;

  // Architectural register number
  typedef logic [4:0] reg_addr_t;

  // ALU operation select
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    // Shift amount comes from port_b[4:0]
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    // Set-less-than gives 1 or 0
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  // Branch compare, encoded as the RISC-V funct3 field
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_funct_t;

  // Multiply flavour
  // HI codes pick the upper word, operands signed/unsigned as named
  typedef enum logic [1:0] {
    MUL_LO    = 2'd0,
    MUL_HI_SS = 2'd1,
    MUL_HI_SU = 2'd2,
    MUL_HI_UU = 2'd3
  } mul_op_t;

endpackage

// ==== rtl/arith_branch_unit.sv ====
// ######################################
// Single-cycle ALU, branch resolution
// and JAL/JALR target calculation
// ######################################

module arith_branch_unit #(
  parameter int CB_INDEX_W = 3
) (
  input  logic                      arith_ena,
  input  execute_pkg::alu_op_t      alu_op,
  input  execute_pkg::word_t        port_a,
  input  execute_pkg::word_t        port_b,
  input  execute_pkg::reg_addr_t    rd,
  input  logic [CB_INDEX_W-1:0]     index,
  input  execute_pkg::word_t        pc,
  input  execute_pkg::word_t        imm,
  input  logic                      branch_instr,
  input  execute_pkg::branch_funct_t branch_funct,
  input  logic                      prediction,
  input  logic                      jump_instr,
  input  logic                      jalr,
  output logic                      wen_au,
  output execute_pkg::word_t        wdata_au,
  output execute_pkg::reg_addr_t    reg_rd_au,
  output logic [CB_INDEX_W-1:0]     index_au,
  output logic                      br_taken,
  output execute_pkg::word_t        br_target,
  output logic                      mispredict,
  output execute_pkg::word_t        brj_addr
);

  execute_pkg::word_t alu_result;
  execute_pkg::word_t pc_plus_4;
  execute_pkg::word_t pc_plus_imm;
  execute_pkg::word_t jump_target;
  logic [4:0]         shamt;
  logic               cmp_result;

  assign shamt       = port_b[4:0];
  assign pc_plus_4   = pc + 32'd4;
  assign pc_plus_imm = pc + imm;

  // ALU
  always_comb begin
    case (alu_op)
      execute_pkg::ALU_ADD:  alu_result = port_a + port_b;
      execute_pkg::ALU_SUB:  alu_result = port_a - port_b;
      execute_pkg::ALU_AND:  alu_result = port_a & port_b;
      execute_pkg::ALU_OR:   alu_result = port_a | port_b;
      execute_pkg::ALU_XOR:  alu_result = port_a ^ port_b;
      execute_pkg::ALU_SLL:  alu_result = port_a << shamt;
      execute_pkg::ALU_SRL:  alu_result = port_a >> shamt;
      execute_pkg::ALU_SRA:  alu_result = $signed(port_a) >>> shamt;
      execute_pkg::ALU_SLT:  alu_result = {31'd0, $signed(port_a) < $signed(port_b)};
      execute_pkg::ALU_SLTU: alu_result = {31'd0, port_a < port_b};
      default:               alu_result = '0;
    endcase
  end

  // Branch compare on the funct3 code
  always_comb begin
    case (branch_funct)
      execute_pkg::BR_BEQ:  cmp_result = (port_a == port_b);
      execute_pkg::BR_BNE:  cmp_result = (port_a != port_b);
      execute_pkg::BR_BLT:  cmp_result = ($signed(port_a) < $signed(port_b));
      execute_pkg::BR_BGE:  cmp_result = ($signed(port_a) >= $signed(port_b));
      execute_pkg::BR_BLTU: cmp_result = (port_a < port_b);
      execute_pkg::BR_BGEU: cmp_result = (port_a >= port_b);
      default:              cmp_result = 1'b0;
    endcase
  end

  assign br_taken   = branch_instr & cmp_result;
  assign br_target  = br_taken ? pc_plus_imm : pc_plus_4;
  assign mispredict = branch_instr & (prediction ^ br_taken);

  // JALR clears bit 0 of the sum
  assign jump_target = jalr ? ((port_a + imm) & ~32'd1) : pc_plus_imm;
  assign brj_addr    = jump_instr ? jump_target : pc_plus_imm;

  // Result group toward the commit latch, jumps write the link value
  assign wen_au    = arith_ena;
  assign wdata_au  = jump_instr ? pc_plus_4 : alu_result;
  assign reg_rd_au = rd;
  assign index_au  = index;

endmodule

// ==== rtl/multiply_pipe.sv ====
// ######################################
// Pipelined 32x32 multiplier with
// destination and index delay line
// ######################################

module multiply_pipe #(
  parameter int CB_INDEX_W  = 3,
  parameter int MUL_LATENCY = 3
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   mult_ena,
  input  execute_pkg::mul_op_t   mult_op,
  input  execute_pkg::word_t     port_a,
  input  execute_pkg::word_t     port_b,
  input  execute_pkg::reg_addr_t rd,
  input  logic [CB_INDEX_W-1:0]  index,
  output logic                   done_mu,
  output execute_pkg::word_t     wdata_mu,
  output execute_pkg::reg_addr_t reg_rd_mu,
  output logic [CB_INDEX_W-1:0]  index_mu
);

  logic                   a_signed;
  logic                   b_signed;
  logic signed [32:0]     a_ext;
  logic signed [32:0]     b_ext;
  logic [63:0]            product;

  // One slot per stage, each holds its own multiply
  logic [MUL_LATENCY-1:0]                 stage_valid;
  logic [MUL_LATENCY-1:0][63:0]           stage_prod;
  logic [MUL_LATENCY-1:0][1:0]            stage_op;
  logic [MUL_LATENCY-1:0][4:0]            stage_rd;
  logic [MUL_LATENCY-1:0][CB_INDEX_W-1:0] stage_index;

  // Extra top bit makes one signed multiply cover all three cases
  assign a_signed = (mult_op == execute_pkg::MUL_HI_SS) || (mult_op == execute_pkg::MUL_HI_SU);
  assign b_signed = (mult_op == execute_pkg::MUL_HI_SS);
  assign a_ext    = {a_signed & port_a[31], port_a};
  assign b_ext    = {b_signed & port_b[31], port_b};
  assign product  = a_ext * b_ext;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      stage_valid <= '0;
      stage_prod  <= '0;
      stage_op    <= '0;
      stage_rd    <= '0;
      stage_index <= '0;
    end else begin
      stage_valid[0] <= mult_ena;
      stage_prod[0]  <= product;
      stage_op[0]    <= mult_op;
      stage_rd[0]    <= rd;
      stage_index[0] <= index;
      for (int i = 1; i < MUL_LATENCY; i++) begin
        stage_valid[i] <= stage_valid[i-1];
        stage_prod[i]  <= stage_prod[i-1];
        stage_op[i]    <= stage_op[i-1];
        stage_rd[i]    <= stage_rd[i-1];
        stage_index[i] <= stage_index[i-1];
      end
    end
  end

  // Last stage picks the half
  assign done_mu   = stage_valid[MUL_LATENCY-1];
  assign wdata_mu  = (stage_op[MUL_LATENCY-1] == execute_pkg::MUL_LO) ?
                     stage_prod[MUL_LATENCY-1][31:0] : stage_prod[MUL_LATENCY-1][63:32];
  assign reg_rd_mu = stage_rd[MUL_LATENCY-1];
  assign index_mu  = stage_index[MUL_LATENCY-1];

endmodule

// ==== rtl/commit_latch.sv ====
// ######################################
// Execute-to-commit register for the
// arithmetic and multiply result groups
// ######################################

module commit_latch #(
  parameter int CB_INDEX_W = 3
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   flush,
  // Arithmetic group
  input  logic                   wen_au,
  input  execute_pkg::word_t     wdata_au,
  input  execute_pkg::reg_addr_t reg_rd_au,
  input  logic [CB_INDEX_W-1:0]  index_au,
  input  logic                   branch_instr,
  input  logic                   br_taken,
  input  execute_pkg::word_t     br_target,
  // Multiply group
  input  logic                   done_mu,
  input  execute_pkg::word_t     wdata_mu,
  input  execute_pkg::reg_addr_t reg_rd_mu,
  input  logic [CB_INDEX_W-1:0]  index_mu,
  // Registered toward commit
  output logic                   c_wen_au,
  output execute_pkg::word_t     c_wdata_au,
  output execute_pkg::reg_addr_t c_reg_rd_au,
  output logic [CB_INDEX_W-1:0]  c_index_au,
  output logic                   c_br_valid,
  output logic                   c_br_taken,
  output execute_pkg::word_t     c_br_target,
  output logic                   c_wen_mu,
  output execute_pkg::word_t     c_wdata_mu,
  output execute_pkg::reg_addr_t c_reg_rd_mu,
  output logic [CB_INDEX_W-1:0]  c_index_mu
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      c_wen_au    <= 1'b0;
      c_wdata_au  <= '0;
      c_reg_rd_au <= '0;
      c_index_au  <= '0;
      c_br_valid  <= 1'b0;
      c_br_taken  <= 1'b0;
      c_br_target <= '0;
      c_wen_mu    <= 1'b0;
      c_wdata_mu  <= '0;
      c_reg_rd_mu <= '0;
      c_index_mu  <= '0;
    end else if (flush) begin
      // Whole latch drops, including anything issued this cycle
      c_wen_au    <= 1'b0;
      c_wdata_au  <= '0;
      c_reg_rd_au <= '0;
      c_index_au  <= '0;
      c_br_valid  <= 1'b0;
      c_br_taken  <= 1'b0;
      c_br_target <= '0;
      c_wen_mu    <= 1'b0;
      c_wdata_mu  <= '0;
      c_reg_rd_mu <= '0;
      c_index_mu  <= '0;
    end else begin
      c_wen_au    <= wen_au;
      c_wdata_au  <= wdata_au;
      c_reg_rd_au <= reg_rd_au;
      c_index_au  <= index_au;
      // Resolved branch for predictor update
      c_br_valid  <= branch_instr;
      c_br_taken  <= br_taken;
      c_br_target <= br_target;
      c_wen_mu    <= done_mu;
      c_wdata_mu  <= wdata_mu;
      c_reg_rd_mu <= reg_rd_mu;
      c_index_mu  <= index_mu;
    end
  end

endmodule

// ==== rtl/execute_stage.sv ====
// ######################################
// Execute stage top level
// ######################################

module execute_stage #(
  parameter int CB_INDEX_W  = 3,
  parameter int MUL_LATENCY = 3
) (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       flush,
  // Issue side
  input  logic                       arith_ena,
  input  execute_pkg::alu_op_t       alu_op,
  input  logic                       mult_ena,
  input  execute_pkg::mul_op_t       mult_op,
  input  execute_pkg::word_t         port_a,
  input  execute_pkg::word_t         port_b,
  input  execute_pkg::reg_addr_t     rd,
  input  logic [CB_INDEX_W-1:0]      index,
  input  execute_pkg::word_t         pc,
  input  execute_pkg::word_t         imm,
  input  logic                       branch_instr,
  input  execute_pkg::branch_funct_t branch_funct,
  input  logic                       prediction,
  input  logic                       jump_instr,
  input  logic                       jalr,
  // Hazard side, same cycle as issue
  output logic                       mispredict,
  output execute_pkg::word_t         brj_addr,
  // Commit side
  output logic                       wen_au,
  output execute_pkg::word_t         wdata_au,
  output execute_pkg::reg_addr_t     reg_rd_au,
  output logic [CB_INDEX_W-1:0]      index_au,
  output logic                       br_valid,
  output logic                       br_taken,
  output execute_pkg::word_t         br_target,
  output logic                       wen_mu,
  output execute_pkg::word_t         wdata_mu,
  output execute_pkg::reg_addr_t     reg_rd_mu,
  output logic [CB_INDEX_W-1:0]      index_mu
);

  logic                   ex_wen_au;
  execute_pkg::word_t     ex_wdata_au;
  execute_pkg::reg_addr_t ex_reg_rd_au;
  logic [CB_INDEX_W-1:0]  ex_index_au;
  logic                   ex_br_taken;
  execute_pkg::word_t     ex_br_target;
  logic                   mu_done;
  execute_pkg::word_t     mu_wdata;
  execute_pkg::reg_addr_t mu_reg_rd;
  logic [CB_INDEX_W-1:0]  mu_index;

  arith_branch_unit #(.CB_INDEX_W(CB_INDEX_W)) u_arith_branch_unit (
    .arith_ena   (arith_ena),
    .alu_op      (alu_op),
    .port_a      (port_a),
    .port_b      (port_b),
    .rd          (rd),
    .index       (index),
    .pc          (pc),
    .imm         (imm),
    .branch_instr(branch_instr),
    .branch_funct(branch_funct),
    .prediction  (prediction),
    .jump_instr  (jump_instr),
    .jalr        (jalr),
    .wen_au      (ex_wen_au),
    .wdata_au    (ex_wdata_au),
    .reg_rd_au   (ex_reg_rd_au),
    .index_au    (ex_index_au),
    .br_taken    (ex_br_taken),
    .br_target   (ex_br_target),
    .mispredict  (mispredict),
    .brj_addr    (brj_addr)
  );

  multiply_pipe #(
    .CB_INDEX_W (CB_INDEX_W),
    .MUL_LATENCY(MUL_LATENCY)
  ) u_multiply_pipe (
    .CLK      (CLK),
    .nRST     (nRST),
    .mult_ena (mult_ena),
    .mult_op  (mult_op),
    .port_a   (port_a),
    .port_b   (port_b),
    .rd       (rd),
    .index    (index),
    .done_mu  (mu_done),
    .wdata_mu (mu_wdata),
    .reg_rd_mu(mu_reg_rd),
    .index_mu (mu_index)
  );

  // Multiplies in flight are not flushed, only the latch is
  commit_latch #(.CB_INDEX_W(CB_INDEX_W)) u_commit_latch (
    .CLK         (CLK),
    .nRST        (nRST),
    .flush       (flush),
    .wen_au      (ex_wen_au),
    .wdata_au    (ex_wdata_au),
    .reg_rd_au   (ex_reg_rd_au),
    .index_au    (ex_index_au),
    .branch_instr(branch_instr),
    .br_taken    (ex_br_taken),
    .br_target   (ex_br_target),
    .done_mu     (mu_done),
    .wdata_mu    (mu_wdata),
    .reg_rd_mu   (mu_reg_rd),
    .index_mu    (mu_index),
    .c_wen_au    (wen_au),
    .c_wdata_au  (wdata_au),
    .c_reg_rd_au (reg_rd_au),
    .c_index_au  (index_au),
    .c_br_valid  (br_valid),
    .c_br_taken  (br_taken),
    .c_br_target (br_target),
    .c_wen_mu    (wen_mu),
    .c_wdata_mu  (wdata_mu),
    .c_reg_rd_mu (reg_rd_mu),
    .c_index_mu  (index_mu)
  );

endmodule

// ==== verif/execute_stage_props.sv ====
// ########################################
// Bound assertions for the execute stage
// with reference ALU, branch and multiply
// ########################################

module execute_stage_props #(
  parameter int CB_INDEX_W  = 3,
  parameter int MUL_LATENCY = 3
) (
  input logic                       CLK, nRST, flush,
  input logic                       arith_ena, mult_ena,
  input execute_pkg::alu_op_t       alu_op,
  input execute_pkg::mul_op_t       mult_op,
  input execute_pkg::word_t         port_a, port_b, pc, imm,
  input execute_pkg::reg_addr_t     rd,
  input logic [CB_INDEX_W-1:0]      index,
  input logic                       branch_instr, prediction, jump_instr, jalr,
  input execute_pkg::branch_funct_t branch_funct,
  // DUT outputs
  input logic                       mispredict, wen_au, br_valid, br_taken, wen_mu,
  input execute_pkg::word_t         brj_addr, wdata_au, br_target, wdata_mu,
  input execute_pkg::reg_addr_t     reg_rd_au, reg_rd_mu,
  input logic [CB_INDEX_W-1:0]      index_au, index_mu
);

  localparam int TAG_W = 5 + CB_INDEX_W;

  logic                              taken_exp;
  logic                              mis_exp;
  execute_pkg::word_t                brj_exp;
  logic [TAG_W+31:0]                 au_hist;
  logic [32:0]                       br_hist;
  logic [MUL_LATENCY:0][TAG_W+31:0]  mul_hist;
  int                                error_count = 0;

  function automatic execute_pkg::word_t alu_ref(input execute_pkg::alu_op_t op,
                                                 input execute_pkg::word_t a,
                                                 input execute_pkg::word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      execute_pkg::ALU_ADD:  return a + b;
      execute_pkg::ALU_SUB:  return a + ~b + 32'd1;
      execute_pkg::ALU_AND:  return a & b;
      execute_pkg::ALU_OR:   return a | b;
      execute_pkg::ALU_XOR:  return a ^ b;
      execute_pkg::ALU_SLL:  return a << sh;
      execute_pkg::ALU_SRL:  return a >> sh;
      // Logical shift plus sign fill
      execute_pkg::ALU_SRA:  return (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh));
      execute_pkg::ALU_SLT:  return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
      execute_pkg::ALU_SLTU: return {31'd0, a < b};
      default:               return '0;
    endcase
  endfunction

  function automatic logic cmp_ref(input execute_pkg::branch_funct_t fn,
                                   input execute_pkg::word_t a,
                                   input execute_pkg::word_t b);
    logic lt_s;
    lt_s = (a[31] != b[31]) ? a[31] : (a < b);
    case (fn)
      execute_pkg::BR_BEQ:  return a == b;
      execute_pkg::BR_BNE:  return a != b;
      execute_pkg::BR_BLT:  return lt_s;
      execute_pkg::BR_BGE:  return !lt_s;
      execute_pkg::BR_BLTU: return a < b;
      execute_pkg::BR_BGEU: return !(a < b);
      default:              return 1'b0;
    endcase
  endfunction

  // Full 64-bit product of the extended operands
  function automatic execute_pkg::word_t mul_ref(input execute_pkg::mul_op_t op,
                                                 input execute_pkg::word_t a,
                                                 input execute_pkg::word_t b);
    logic [63:0] xa;
    logic [63:0] xb;
    logic [63:0] p;
    xa = (op == execute_pkg::MUL_HI_UU) ? {32'd0, a} : {{32{a[31]}}, a};
    xb = (op == execute_pkg::MUL_HI_SU || op == execute_pkg::MUL_HI_UU) ?
         {32'd0, b} : {{32{b[31]}}, b};
    p  = xa * xb;
    return (op == execute_pkg::MUL_LO) ? p[31:0] : p[63:32];
  endfunction

  task automatic record_failure(input string msg);
    $error("%s", msg);
    error_count++;
  endtask

  assign taken_exp = cmp_ref(branch_funct, port_a, port_b);
  assign mis_exp   = branch_instr & (prediction ^ taken_exp);
  assign brj_exp   = (jump_instr && jalr) ? (port_a + imm) & 32'hffff_fffe : pc + imm;

  // Expected results lined up with the commit outputs
  always_ff @(posedge CLK) begin
    au_hist  <= {rd, index, jump_instr ? pc + 32'd4 : alu_ref(alu_op, port_a, port_b)};
    br_hist  <= {taken_exp, taken_exp ? pc + imm : pc + 32'd4};
    mul_hist <= {mul_hist[MUL_LATENCY-1:0], {rd, index, mul_ref(mult_op, port_a, port_b)}};
  end

  a_reset: assert property (@(posedge CLK)
    !nRST || !$past(nRST) |-> !wen_au && !wen_mu && !br_valid)
    else record_failure($sformatf("Fail reset: expected 000, actual %b%b%b",
                                  wen_au, wen_mu, br_valid));

  a_result_au: assert property (@(posedge CLK) disable iff (!nRST)
    $past(arith_ena) && !$past(flush) |-> wen_au && {reg_rd_au, index_au, wdata_au} == au_hist)
    else record_failure($sformatf("Fail result_au: expected %h, actual %h",
                                  {1'b1, au_hist}, {wen_au, reg_rd_au, index_au, wdata_au}));

  a_mispredict: assert property (@(posedge CLK) disable iff (!nRST)
    mispredict == mis_exp)
    else record_failure($sformatf("Fail mispredict: expected %b, actual %b",
                                  mis_exp, mispredict));

  a_branch: assert property (@(posedge CLK) disable iff (!nRST)
    $past(branch_instr) && !$past(flush) |-> br_valid && {br_taken, br_target} == br_hist)
    else record_failure($sformatf("Fail branch: expected %h, actual %h",
                                  {1'b1, br_hist}, {br_valid, br_taken, br_target}));

  a_brj_addr: assert property (@(posedge CLK) disable iff (!nRST)
    brj_addr == brj_exp)
    else record_failure($sformatf("Fail brj_addr: expected %h, actual %h",
                                  brj_exp, brj_addr));

  a_multiply: assert property (@(posedge CLK) disable iff (!nRST)
    $past(mult_ena, MUL_LATENCY + 1) && !$past(flush) |->
      wen_mu && {reg_rd_mu, index_mu, wdata_mu} == mul_hist[MUL_LATENCY])
    else record_failure($sformatf("Fail multiply: expected %h, actual %h",
                                  {1'b1, mul_hist[MUL_LATENCY]},
                                  {wen_mu, reg_rd_mu, index_mu, wdata_mu}));

  a_flush: assert property (@(posedge CLK) disable iff (!nRST)
    $past(flush) |-> !wen_au && !wen_mu && !br_valid)
    else record_failure($sformatf("Fail flush: expected 000, actual %b%b%b",
                                  wen_au, wen_mu, br_valid));

endmodule

bind execute_stage execute_stage_props #(
  .CB_INDEX_W (CB_INDEX_W),
  .MUL_LATENCY(MUL_LATENCY)
) u_props (.*);

// ==== verif/execute_stage_tb.sv ====
// ########################################
// Execute stage testbench
// Clock, reset, LFSR stimulus, timeout
// ########################################

module execute_stage_tb;

  localparam int CB_INDEX_W   = 3;
  localparam int MUL_LATENCY  = 3;
  localparam int RESET_CYCLES = 8;
  localparam int STIM_CYCLES  = 400;
  // About five times the length of the run
  localparam int TIMEOUT_CYCLES = 5 * STIM_CYCLES;

  logic                       CLK;
  logic                       nRST;
  logic                       flush;
  logic                       arith_ena;
  logic                       mult_ena;
  execute_pkg::alu_op_t       alu_op;
  execute_pkg::mul_op_t       mult_op;
  execute_pkg::word_t         port_a;
  execute_pkg::word_t         port_b;
  execute_pkg::word_t         pc;
  execute_pkg::word_t         imm;
  execute_pkg::reg_addr_t     rd;
  logic [CB_INDEX_W-1:0]      index;
  logic                       branch_instr;
  execute_pkg::branch_funct_t branch_funct;
  logic                       prediction;
  logic                       jump_instr;
  logic                       jalr;

  // DUT outputs
  logic                       mispredict;
  logic                       wen_au;
  logic                       br_valid;
  logic                       br_taken;
  logic                       wen_mu;
  execute_pkg::word_t         brj_addr;
  execute_pkg::word_t         wdata_au;
  execute_pkg::word_t         br_target;
  execute_pkg::word_t         wdata_mu;
  execute_pkg::reg_addr_t     reg_rd_au;
  execute_pkg::reg_addr_t     reg_rd_mu;
  logic [CB_INDEX_W-1:0]      index_au;
  logic [CB_INDEX_W-1:0]      index_mu;

  logic [31:0]                lfsr_state;
  int                         cycle_count = 0;

  execute_stage #(
    .CB_INDEX_W (CB_INDEX_W),
    .MUL_LATENCY(MUL_LATENCY)
  ) u_execute_stage (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Fibonacci LFSR with taps 32 22 2 1, stepped once per bit
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits       = {bits[30:0], fb};
    end
    return bits;
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("Error: %s", reason);
    $display("Simulation failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic drive_idle();
    flush        <= 1'b0;
    arith_ena    <= 1'b0;
    mult_ena     <= 1'b0;
    alu_op       <= execute_pkg::ALU_ADD;
    mult_op      <= execute_pkg::MUL_LO;
    port_a       <= '0;
    port_b       <= '0;
    pc           <= '0;
    imm          <= '0;
    rd           <= '0;
    index        <= '0;
    branch_instr <= 1'b0;
    branch_funct <= execute_pkg::BR_BEQ;
    prediction   <= 1'b0;
    jump_instr   <= 1'b0;
    jalr         <= 1'b0;
  endtask

  task automatic drive_random();
    logic [31:0] sel;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] ofs;
    logic [31:0] tag;
    logic [2:0]  fn;
    sel  = random_bits(24);
    a    = random_bits(32);
    b    = random_bits(32);
    addr = random_bits(30);
    ofs  = random_bits(11);
    tag  = random_bits(5 + CB_INDEX_W);
    fn   = sel[14:12];
    // 010 and 011 are not branch codes
    if (fn[2:1] == 2'b01) begin
      fn[2] = 1'b1;
    end
    flush        <= (sel[3:0] == 4'd0);
    arith_ena    <= sel[4];
    mult_ena     <= sel[5];
    branch_instr <= (sel[7:6] == 2'b11);
    prediction   <= sel[8];
    jump_instr   <= (sel[10:9] == 2'b11);
    jalr         <= sel[11];
    branch_funct <= execute_pkg::branch_funct_t'(fn);
    alu_op       <= execute_pkg::alu_op_t'(sel[18:15] % 4'd10);
    mult_op      <= execute_pkg::mul_op_t'(sel[20:19]);
    port_a       <= a;
    // Equal operands now and then so compares see ties
    port_b       <= (sel[23:21] == 3'd0) ? a : b;
    pc           <= {addr[29:0], 2'b00};
    imm          <= {{20{ofs[10]}}, ofs[10:0], 1'b0};
    rd           <= tag[4:0];
    index        <= tag[CB_INDEX_W+4:5];
  endtask

  initial begin
    lfsr_state = 32'h7bd5e18c;
    nRST = 1'b0;
    drive_idle();
    repeat (RESET_CYCLES) @(posedge CLK);
    nRST <= 1'b1;
    repeat (STIM_CYCLES) begin
      @(posedge CLK);
      drive_random();
    end
    @(posedge CLK);
    drive_idle();
    // Last multiplies drain through the pipe and the latch
    repeat (MUL_LATENCY + 3) @(posedge CLK);
    if (u_execute_stage.u_props.error_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      stop_with_failure("assertion failures were recorded");
    end
  end

  always @(negedge CLK) begin
    if (u_execute_stage.u_props.error_count != 0) begin
      stop_with_failure("an assertion on the execute stage failed");
    end
  end

  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      stop_with_failure("the run did not reach its end before the cycle limit");
    end
  end

endmodule

// ==== list.f ====
rtl/execute_pkg.sv
rtl/arith_branch_unit.sv
rtl/multiply_pipe.sv
rtl/commit_latch.sv
rtl/execute_stage.sv
verif/execute_stage_props.sv
verif/execute_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module execute_stage_tb
out=$(./obj_dir/Vexecute_stage_tb +verilator+error+limit+1000 2>&1 || true)
echo "$out"
if echo "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
